//--- filelist.f
src/i2c_pkg.sv
src/touch_pkg.sv
src/phase_timer.sv
src/i2c_bit_engine.sv
src/i2c_byte_engine.sv
src/touch_sequencer.sv
src/touch_i2c_reader.sv
test/touch_slave_model.sv
test/tb_touch_i2c_reader.sv

//--- Bender.yml
package:
  name: touch_i2c_reader

sources:
  - src/i2c_pkg.sv
  - src/touch_pkg.sv
  - src/phase_timer.sv
  - src/i2c_bit_engine.sv
  - src/i2c_byte_engine.sv
  - src/touch_sequencer.sv
  - src/touch_i2c_reader.sv
  - target: test
    files:
      - test/touch_slave_model.sv
      - test/tb_touch_i2c_reader.sv

//--- test/tb_touch_i2c_reader.sv
`timescale 1ns/100ps

module tb_touch_i2c_reader;
   import i2c_pkg::*;
   import touch_pkg::*;

   localparam int          CLK_PERIOD = 10;
   localparam int          N_IRQ      = 6;   // First one without stretching
   localparam logic [15:0] LFSR_SEED  = 16'd13367;
   localparam longint      WATCHDOG_NS =
      longint'(N_IRQ) * 480 * (PHASE_TICKS + 20) * CLK_PERIOD + 20 * CLK_PERIOD;

   logic            clk = 1'b0;
   logic            nRst;
   logic            inter;
   logic            sda_out;
   logic            sda_oeb;
   logic            scl_out;
   logic            done;
   touch_word_u     data_out;
   logic            sda_bus;
   logic            scl_bus;
   logic            sda_pull;
   logic            scl_pull;
   logic            proto_err;
   logic [3:0]      stretch_len = '0;
   logic            stretch_on = 1'b0;
   logic [0:3][7:0] regs = '0;
   logic [31:0]     exp_word = '0;
   logic [15:0]     exp_x = '0;
   logic [15:0]     exp_y = '0;
   logic [31:0]     last_word = '0;
   logic            prev_done = 1'b1;
   int              words_checked = 0;
   logic [15:0]     lfsr = LFSR_SEED;

   // Open-drain bus, low wins
   assign sda_bus = !((!sda_oeb && !sda_out) || sda_pull);
   assign scl_bus = scl_out && !scl_pull;

   always #(CLK_PERIOD / 2) clk = ~clk;

   touch_i2c_reader dut0 (
      .clk      (clk),
      .nRst     (nRst),
      .inter    (inter),
      .sda_in   (sda_bus),
      .scl_in   (scl_bus),
      .sda_out  (sda_out),
      .sda_oeb  (sda_oeb),
      .scl_out  (scl_out),
      .data_out (data_out),
      .done     (done)
   );

   touch_slave_model slave0 (
      .clk         (clk),
      .scl_m       (scl_out),
      .scl         (scl_bus),
      .sda         (sda_bus),
      .stretch_len (stretch_len),
      .regs        (regs),
      .scl_pull    (scl_pull),
      .sda_pull    (sda_pull),
      .proto_err   (proto_err)
   );

   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [7:0] take_bits(input int n);
      logic [7:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v    = {v[6:0], lfsr[0]};
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   // XH in the top byte, YL in the bottom byte
   function automatic logic [31:0] expected_word(input logic [0:3][7:0] r);
      return {r[0], r[1], r[2], r[3]};
   endfunction

   // New stretch length for each bit, set while SCL is low
   always @(negedge scl_out) begin
      #1;
      stretch_len = stretch_on ? 4'(take_bits(4)) : 4'd0;
   end

   always @(posedge proto_err) begin
      stop_with_failure("The slave model saw a bus protocol error");
   end

   initial begin
      #(WATCHDOG_NS);
      stop_with_failure("Timeout: the reader did not finish its reads in time");
   end

   // Comparison, sampled mid-cycle
   always @(negedge clk) begin
      if (nRst) begin
         if (!done) begin
            assert (data_out == last_word) else stop_with_failure(
               $sformatf("Error: data_out = %h while busy, expected %h", data_out, last_word));
         end
         if (done && !prev_done) begin
            assert (data_out == exp_word) else stop_with_failure(
               $sformatf("Error: data_out = %h, expected %h", data_out, exp_word));
            assert (data_out.pos.x == exp_x) else stop_with_failure(
               $sformatf("Error: data_out.pos.x = %h, expected %h", data_out.pos.x, exp_x));
            assert (data_out.pos.y == exp_y) else stop_with_failure(
               $sformatf("Error: data_out.pos.y = %h, expected %h", data_out.pos.y, exp_y));
            last_word     = exp_word;
            words_checked = words_checked + 1;
         end
         prev_done = done;
      end
   end

   initial begin
      int n;
      nRst  = 1'b0;
      inter = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      nRst = 1'b1;
      @(negedge clk);
      assert (done) else stop_with_failure($sformatf("Error: done = %h, expected 1", done));
      assert (data_out == '0) else
         stop_with_failure($sformatf("Error: data_out = %h, expected 0", data_out));
      assert (scl_out && sda_out && !sda_oeb) else stop_with_failure($sformatf(
         "Error: scl_out/sda_out/sda_oeb = %h/%h/%h, expected 1/1/0", scl_out, sda_out, sda_oeb));
      for (int i = 0; i < N_IRQ; i++) begin
         @(posedge clk);
         #1;
         stretch_on = (i != 0);
         for (int k = 0; k < 4; k++) begin
            regs[k] = take_bits(8);
         end
         exp_word = expected_word(regs);
         exp_x    = {regs[0], regs[1]};
         exp_y    = {regs[2], regs[3]};
         inter    = 1'b0;
         n        = 0;
         while (done && n < 4) begin
            @(posedge clk);
            #1;
            n++;
         end
         assert (!done) else stop_with_failure("done did not fall within 4 cycles of the interrupt");
         inter = 1'b1;
         wait (words_checked == i + 1);
      end
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

//--- test/touch_slave_model.sv
`timescale 1ns/100ps

module touch_slave_model (
   input  logic            clk,
   input  logic            scl_m,         // SCL as driven by the master
   input  logic            scl,           // Bus SCL
   input  logic            sda,           // Bus SDA
   input  logic [3:0]      stretch_len,   // 0 disables stretching
   input  logic [0:3][7:0] regs,          // XH, XL, YH, YL
   output logic            scl_pull,
   output logic            sda_pull,
   output logic            proto_err
);

   // Bus phases of one register read
   localparam int P_START_W = 0;
   localparam int P_ADDR_W  = 1;
   localparam int P_REG     = 2;
   localparam int P_STOP_W  = 3;
   localparam int P_START_R = 4;
   localparam int P_ADDR_R  = 5;
   localparam int P_DATA    = 6;
   localparam int P_STOP_R  = 7;

   int         phase = P_START_W;
   int         bit_cnt = 0;
   logic [1:0] reg_cnt = '0;
   logic [7:0] shreg = '0;
   logic [3:0] stretch_cnt = '0;
   logic       prev_scl = 1'b1;
   logic       prev_sda = 1'b1;
   logic       prev_scl_m = 1'b1;

   initial begin
      scl_pull  = 1'b0;
      sda_pull  = 1'b0;
      proto_err = 1'b0;
   end

   task automatic report_error(input string msg);
      $display("%s", msg);
      proto_err = 1'b1;
   endtask

   always @(posedge clk) begin
      logic       start_ok;
      logic       stop_ok;
      logic       in_byte;
      logic       sda_next;
      logic       scl_next;
      logic [7:0] expected;
      sda_next = sda_pull;
      scl_next = scl_pull;
      if (prev_scl && scl && prev_sda !== sda) begin   // SDA moved with SCL high
         start_ok = !sda && (phase == P_START_W || phase == P_START_R);
         stop_ok  = sda && (phase == P_STOP_W || phase == P_STOP_R);
         assert (start_ok || stop_ok) else
            report_error($sformatf("SDA changed while SCL was high in bus phase %0d", phase));
         if (start_ok) begin
            phase   = phase + 1;
            bit_cnt = 0;
         end else if (stop_ok && phase == P_STOP_W) begin
            phase = P_START_R;
         end else if (stop_ok) begin
            phase   = P_START_W;
            reg_cnt = reg_cnt + 2'd1;
         end
      end
      in_byte = (phase == P_ADDR_W) || (phase == P_REG) || (phase == P_ADDR_R) ||
                (phase == P_DATA);
      if (!prev_scl && scl && in_byte) begin
         if (phase == P_DATA && bit_cnt == 8) begin
            assert (sda) else report_error("Master acknowledged the data byte instead of a NACK");
         end
         shreg   = {shreg[6:0], sda};
         bit_cnt = bit_cnt + 1;
      end
      if (prev_scl && !scl && in_byte) begin
         if (phase == P_DATA) begin
            if (bit_cnt < 8) begin
               sda_next = !regs[reg_cnt][7 - bit_cnt];
            end else if (bit_cnt == 8) begin
               sda_next = 1'b0;   // Master's NACK slot
            end else begin
               bit_cnt = 0;
               phase   = P_STOP_R;
            end
         end else if (bit_cnt == 8) begin
            if (phase == P_ADDR_W) begin
               expected = 8'h70;
            end else if (phase == P_ADDR_R) begin
               expected = 8'h71;
            end else begin
               expected = 8'h03 + reg_cnt;
            end
            assert (shreg == expected) else
               report_error($sformatf("Error: received byte = %h, expected %h", shreg, expected));
            sda_next = 1'b1;   // ACK
         end else if (bit_cnt == 9) begin
            sda_next = 1'b0;
            bit_cnt  = 0;
            phase    = phase + 1;
            if (phase == P_DATA) begin
               sda_next = !regs[reg_cnt][7];
            end
         end
      end
      // Stretch from the master's SCL fall until stretch_len cycles after its release
      assert (!(scl_pull && prev_scl_m && !scl_m)) else
         report_error("Master pulled SCL low while the slave was stretching the clock");
      if (prev_scl_m && !scl_m && stretch_len != 0) begin
         scl_next    = 1'b1;
         stretch_cnt = stretch_len;
      end else if (scl_pull && scl_m) begin
         stretch_cnt = stretch_cnt - 4'd1;
         if (stretch_cnt == 0) begin
            scl_next = 1'b0;
         end
      end
      prev_scl   = scl;
      prev_sda   = sda;
      prev_scl_m = scl_m;
      #1;
      sda_pull = sda_next;
      scl_pull = scl_next;
   end

endmodule

//--- src/touch_i2c_reader.sv
`timescale 1ns/100ps

module touch_i2c_reader (
   input  logic                   clk,
   input  logic                   nRst,
   input  logic                   inter,
   input  logic                   sda_in,
   input  logic                   scl_in,
   output logic                   sda_out,
   output logic                   sda_oeb,
   output logic                   scl_out,
   output touch_pkg::touch_word_u data_out,
   output logic                   done
);
   import i2c_pkg::*;

   byte_req_t byte_req;
   byte_rsp_t byte_rsp;
   bit_req_t  bit_req;
   bit_rsp_t  bit_rsp;
   logic      timer_start;
   logic      timer_expire;

   touch_sequencer sequencer0 (
      .clk      (clk),
      .nRst     (nRst),
      .inter    (inter),
      .byte_req (byte_req),
      .byte_rsp (byte_rsp),
      .data_out (data_out),
      .done     (done)
   );

   i2c_byte_engine byte_engine0 (
      .clk      (clk),
      .nRst     (nRst),
      .byte_req (byte_req),
      .byte_rsp (byte_rsp),
      .bit_req  (bit_req),
      .bit_rsp  (bit_rsp)
   );

   i2c_bit_engine bit_engine0 (
      .clk          (clk),
      .nRst         (nRst),
      .bit_req      (bit_req),
      .bit_rsp      (bit_rsp),
      .timer_expire (timer_expire),
      .timer_start  (timer_start),
      .scl_in       (scl_in),
      .sda_in       (sda_in),
      .scl_out      (scl_out),
      .sda_out      (sda_out),
      .sda_oeb      (sda_oeb)
   );

   // Quarter-bit timing
   phase_timer timer0 (
      .clk          (clk),
      .nRst         (nRst),
      .timer_start  (timer_start),
      .timer_expire (timer_expire)
   );

endmodule

//--- src/touch_sequencer.sv
`timescale 1ns/100ps

module touch_sequencer (
   input  logic                   clk,
   input  logic                   nRst,
   input  logic                   inter,
   output i2c_pkg::byte_req_t     byte_req,
   input  i2c_pkg::byte_rsp_t     byte_rsp,
   output touch_pkg::touch_word_u data_out,
   output logic                   done
);
   import i2c_pkg::*;
   import touch_pkg::*;

   typedef enum logic [1:0] {
      S_IDLE,
      S_ISSUE,
      S_WAIT
   } seq_state_e;

   seq_state_e                      state;
   logic                            inter_meta;
   logic                            inter_sync;
   logic [2:0]                      step;   // Byte operation within one register read
   logic [$clog2(N_COORD_REGS)-1:0] reg_idx;
   logic                            last_reg;
   touch_word_u                     work;

   assign done     = (state == S_IDLE);
   assign last_reg = (int'(reg_idx) == N_COORD_REGS - 1);

   always_comb begin
      byte_req.valid = (state == S_ISSUE);
      byte_req.op    = OP_WRITE;
      byte_req.data  = '1;
      case (step)
         3'd0, 3'd4: byte_req.op = OP_START;
         3'd1:       byte_req.data = {SLAVE_ADDR, 1'b0};
         3'd2:       byte_req.data = FIRST_COORD_REG + 8'(reg_idx);
         3'd5:       byte_req.data = {SLAVE_ADDR, 1'b1};
         3'd6:       byte_req.op = OP_READ;
         default:    byte_req.op = OP_STOP;   // Steps 3 and 7
      endcase
   end

   // Data byte of the current register into its lane
   always_ff @(posedge clk) begin
      if (state == S_WAIT && byte_rsp.done && step == 3'd6) begin
         work.lane[reg_idx] <= byte_rsp.data;
      end
   end

   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         inter_meta <= 1'b1;
         inter_sync <= 1'b1;
         state      <= S_IDLE;
         step       <= '0;
         reg_idx    <= '0;
         data_out   <= '0;
      end else begin
         inter_meta <= inter;
         inter_sync <= inter_meta;
         case (state)
            S_IDLE: begin
               if (!inter_sync) begin   // Active low
                  step    <= '0;
                  reg_idx <= '0;
                  state   <= S_ISSUE;
               end
            end
            S_ISSUE: state <= S_WAIT;
            S_WAIT: begin
               if (byte_rsp.done) begin
                  if (step == 3'd7) begin
                     step <= '0;
                     if (last_reg) begin
                        data_out <= work;
                        state    <= S_IDLE;
                     end else begin
                        reg_idx <= reg_idx + 1'b1;
                        state   <= S_ISSUE;
                     end
                  end else begin
                     step  <= step + 3'd1;
                     state <= S_ISSUE;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

endmodule

//--- src/i2c_byte_engine.sv
`timescale 1ns/100ps

module i2c_byte_engine (
   input  logic               clk,
   input  logic               nRst,
   input  i2c_pkg::byte_req_t byte_req,
   output i2c_pkg::byte_rsp_t byte_rsp,
   output i2c_pkg::bit_req_t  bit_req,
   input  i2c_pkg::bit_rsp_t  bit_rsp
);
   import i2c_pkg::*;

   typedef enum logic [1:0] {
      Y_IDLE,
      Y_ISSUE,
      Y_WAIT,
      Y_DONE
   } byte_state_e;

   byte_state_e state;
   byte_op_e    op;
   logic [3:0]  slot;
   logic [7:0]  shreg;
   logic        last_slot;

   assign last_slot     = (slot == 4'd8);   // ACK or NACK slot
   assign byte_rsp.done = (state == Y_DONE);
   assign byte_rsp.data = shreg;

   always_comb begin
      bit_req.valid = (state == Y_ISSUE);
      bit_req.wbit  = last_slot ? 1'b1 : shreg[7];
      bit_req.op    = BIT_START;
      case (op)
         OP_START: bit_req.op = BIT_START;
         OP_STOP:  bit_req.op = BIT_STOP;
         OP_WRITE: begin
            if (last_slot) begin
               bit_req.op = BIT_READ;    // Slave ACK, not checked
            end else begin
               bit_req.op = BIT_WRITE;
            end
         end
         default: begin
            if (last_slot) begin
               bit_req.op = BIT_WRITE;   // NACK ends the read
            end else begin
               bit_req.op = BIT_READ;
            end
         end
      endcase
   end

   // MSB first, write data out and read data in
   always_ff @(posedge clk) begin
      if (state == Y_IDLE && byte_req.valid) begin
         op    <= byte_req.op;
         shreg <= byte_req.data;
      end else if (state == Y_WAIT && bit_rsp.done && !last_slot) begin
         shreg <= {shreg[6:0], bit_rsp.rbit};
      end
   end

   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         state <= Y_IDLE;
         slot  <= '0;
      end else begin
         case (state)
            Y_IDLE: begin
               if (byte_req.valid) begin
                  slot  <= '0;
                  state <= Y_ISSUE;
               end
            end
            Y_ISSUE: state <= Y_WAIT;
            Y_WAIT: begin
               if (bit_rsp.done) begin
                  if (op == OP_START || op == OP_STOP || last_slot) begin
                     state <= Y_DONE;
                  end else begin
                     slot  <= slot + 4'd1;
                     state <= Y_ISSUE;
                  end
               end
            end
            default: state <= Y_IDLE;
         endcase
      end
   end

endmodule

//--- src/i2c_bit_engine.sv
`timescale 1ns/100ps

module i2c_bit_engine (
   input  logic              clk,
   input  logic              nRst,
   input  i2c_pkg::bit_req_t bit_req,
   output i2c_pkg::bit_rsp_t bit_rsp,
   input  logic              timer_expire,
   output logic              timer_start,
   input  logic              scl_in,
   input  logic              sda_in,
   output logic              scl_out,
   output logic              sda_out,
   output logic              sda_oeb
);
   import i2c_pkg::*;

   typedef enum logic [1:0] {
      B_IDLE,
      B_ARM,    // Restart timer, apply levels of this step
      B_WAIT,
      B_DONE
   } bit_state_e;

   bit_state_e state;
   logic [1:0] step;
   bit_op_e    op;
   logic       wbit;
   logic       rbit;
   logic       high_end;

   assign timer_start  = (state == B_ARM);
   assign bit_rsp.done = (state == B_DONE);
   assign bit_rsp.rbit = rbit;

   // End of the SCL-high step of a data bit
   assign high_end = (state == B_WAIT) && timer_expire && (step == 2'd1) &&
                     (op == BIT_WRITE || op == BIT_READ);

   always_ff @(posedge clk) begin
      if (state == B_IDLE && bit_req.valid) begin
         op   <= bit_req.op;
         wbit <= bit_req.wbit;
      end
      if (high_end && scl_in && op == BIT_READ) begin
         rbit <= sda_in;
      end
   end

   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         state   <= B_IDLE;
         step    <= '0;
         scl_out <= 1'b1;
         sda_out <= 1'b1;
         sda_oeb <= 1'b0;
      end else begin
         case (state)
            B_IDLE: begin
               if (bit_req.valid) begin
                  step  <= '0;
                  state <= B_ARM;
               end
            end
            B_ARM: begin
               state <= B_WAIT;
               case (step)
                  2'd0: begin
                     case (op)
                        BIT_STOP:  sda_out <= 1'b0;
                        BIT_WRITE: sda_out <= wbit;   // Setup while SCL low
                        BIT_READ: begin
                           sda_out <= 1'b1;
                           sda_oeb <= 1'b1;
                        end
                        default: begin end
                     endcase
                  end
                  2'd1: begin
                     if (op == BIT_START) begin
                        sda_out <= 1'b0;
                     end else begin
                        scl_out <= 1'b1;
                     end
                  end
                  default: begin
                     if (op == BIT_STOP) begin
                        sda_out <= 1'b1;   // SDA rises with SCL high
                     end else begin
                        scl_out <= 1'b0;
                     end
                  end
               endcase
            end
            B_WAIT: begin
               if (timer_expire) begin
                  if (high_end && !scl_in) begin
                     state <= B_ARM;   // Slave stretching, another high phase
                  end else if (step == 2'd2) begin
                     state <= B_DONE;
                  end else begin
                     step  <= step + 2'd1;
                     state <= B_ARM;
                  end
               end
            end
            default: begin
               sda_oeb <= 1'b0;
               state   <= B_IDLE;
            end
         endcase
      end
   end

endmodule

//--- src/phase_timer.sv
`timescale 1ns/100ps

module phase_timer (
   input  logic clk,
   input  logic nRst,
   input  logic timer_start,
   output logic timer_expire
);
   import i2c_pkg::*;

   typedef enum logic {
      T_IDLE,
      T_COUNT
   } timer_state_e;

   timer_state_e           state;
   logic [PHASE_CNT_W-1:0] count;

   assign timer_expire = (state == T_COUNT) && (count == PHASE_CNT_W'(PHASE_TICKS - 1));

   always_ff @(posedge clk, negedge nRst) begin
      if (!nRst) begin
         state <= T_IDLE;
         count <= '0;
      end else begin
         case (state)
            T_IDLE: begin
               if (timer_start) begin
                  state <= T_COUNT;
                  count <= '0;
               end
            end
            default: begin
               count <= count + 1'b1;
               if (timer_expire) begin
                  state <= T_IDLE;   // One phase per start
               end
            end
         endcase
      end
   end

endmodule

//--- src/touch_pkg.sv
package touch_pkg;

   localparam int N_COORD_REGS = 4;
   localparam logic [7:0] FIRST_COORD_REG = 8'h03;   // XH, then XL, YH, YL

   typedef struct packed {
      logic [15:0] x;
      logic [15:0] y;
   } touch_pos_t;

   // Lane 0 is XH in the top byte
   typedef union packed {
      logic [0:N_COORD_REGS-1][7:0] lane;
      touch_pos_t                   pos;
   } touch_word_u;

endpackage

//--- src/i2c_pkg.sv
package i2c_pkg;

   localparam int PHASE_TICKS = 256;       // Clocks per quarter bit
   localparam int PHASE_CNT_W = 8;
   localparam logic [6:0] SLAVE_ADDR = 7'h38;

   typedef enum logic [1:0] {
      OP_START,
      OP_STOP,
      OP_WRITE,
      OP_READ
   } byte_op_e;

   typedef enum logic [1:0] {
      BIT_START,
      BIT_STOP,
      BIT_WRITE,
      BIT_READ
   } bit_op_e;

   typedef struct packed {
      logic    valid;
      bit_op_e op;
      logic    wbit;
   } bit_req_t;

   typedef struct packed {
      logic done;
      logic rbit;
   } bit_rsp_t;

   typedef struct packed {
      logic       valid;
      byte_op_e   op;
      logic [7:0] data;
   } byte_req_t;

   typedef struct packed {
      logic       done;
      logic [7:0] data;
   } byte_rsp_t;

endpackage
